// ==== Bender.yml ====
package:
  name: rename_slice

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - core_types_pkg.sv
      - ready_table.sv
      - free_list.sv
      - rename_alloc.sv
      - rename_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - rename_tb.sv

// ==== core_defs.svh ====
// ----------------------------
// sizing defines for the rename slice
// register counts, index width, lane and port counts
// ----------------------------

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// physical and architectural register file sizes
`define PR_COUNT 64
`define AR_COUNT 32
`define LOG_PR_COUNT 6

// rename group width and ready table port counts
`define RENAME_WIDTH 4
`define RT_READ_PORTS (2 * `RENAME_WIDTH)
`define RT_SET_PORTS 4
`define RT_CLEAR_PORTS `RENAME_WIDTH
// commit frees per cycle
`define COMMIT_WIDTH 4
`define LANE_CNT_WIDTH ($clog2(`RENAME_WIDTH + 1))

`endif

// ==== core_types_pkg.sv ====
// ----------------------------
// shared types for the rename slice
// ----------------------------

`default_nettype none

`include "core_defs.svh"

package core_types_pkg;

    // ----------------------------
    // register indices
    // ----------------------------

    // physical register index
    // wraps naturally since PR_COUNT is a power of two
    typedef logic [`LOG_PR_COUNT-1:0] pr_t;

    // ----------------------------
    // group masks
    // ----------------------------

    // one bit per rename lane
    // used for lane valid and dest needed
    typedef logic [`RENAME_WIDTH-1:0] lane_mask_t;

endpackage

`default_nettype wire

// ==== free_list.sv ====
// ----------------------------
// free PR FIFO with 4 pop-peek and
// 4 compacted push ports
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module free_list (
    input  logic                                     CLK,
    input  logic                                     nRST,

    // oldest free entries, head first
    output core_types_pkg::pr_t [`RENAME_WIDTH-1:0]  head_pr,
    output logic [`LOG_PR_COUNT:0]                   free_count,
    // entries taken this cycle, 0 to RENAME_WIDTH
    input  logic [`LANE_CNT_WIDTH-1:0]               pop_count,

    // freed PRs from commit
    input  logic [`COMMIT_WIDTH-1:0]                 push_valid,
    input  core_types_pkg::pr_t [`COMMIT_WIDTH-1:0]  push_pr
);

    import core_types_pkg::*;

    localparam int CNT_W      = `LOG_PR_COUNT + 1;
    localparam int PUSH_CNT_W = $clog2(`COMMIT_WIDTH + 1);

    // ----------------------------
    // storage and pointers
    // ----------------------------

    pr_t                  fl_mem [`PR_COUNT];
    pr_t                  head_q;
    pr_t                  tail_q;
    logic [CNT_W-1:0]     count_q;

    // compacted push slots
    pr_t                  push_idx [`COMMIT_WIDTH];
    logic [PUSH_CNT_W-1:0] push_cnt;
    pr_t                  peek_idx [`RENAME_WIDTH];

    // ----------------------------
    // peek and push compaction
    // ----------------------------

    always_comb begin
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            peek_idx[k] = head_q + pr_t'(k);
            head_pr[k]  = fl_mem[peek_idx[k]];
        end
    end

    // valid pushes pack down to consecutive slots at the tail
    always_comb begin
        push_cnt = '0;
        for (int p = 0; p < `COMMIT_WIDTH; p++) begin
            push_idx[p] = tail_q + pr_t'(push_cnt);
            if (push_valid[p]) begin
                push_cnt = push_cnt + PUSH_CNT_W'(1);
            end
        end
    end

    assign free_count = count_q;

    // ----------------------------
    // updates
    // ----------------------------

    // entry i starts as PR AR_COUNT+i, so slots 0..count-1 hold the unmapped PRs
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `PR_COUNT; i++) begin
                fl_mem[i] <= pr_t'(i + `AR_COUNT);
            end
        end else begin
            for (int p = 0; p < `COMMIT_WIDTH; p++) begin
                if (push_valid[p]) begin
                    fl_mem[push_idx[p]] <= push_pr[p];
                end
            end
        end
    end

    // pointer math wraps at PR_COUNT
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head_q  <= '0;
            tail_q  <= pr_t'(`PR_COUNT - `AR_COUNT);
            count_q <= CNT_W'(`PR_COUNT - `AR_COUNT);
        end else begin
            head_q  <= head_q + pr_t'(pop_count);
            tail_q  <= tail_q + pr_t'(push_cnt);
            count_q <= count_q + CNT_W'(push_cnt) - CNT_W'(pop_count);
        end
    end

endmodule

`default_nettype wire

// ==== ready_table.sv ====
// ----------------------------
// per-PR ready bits, 8 read / 4 set / 4 clear
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ready_table (
    input  logic                                      CLK,
    input  logic                                      nRST,

    // read ports, two per rename lane
    input  core_types_pkg::pr_t [`RT_READ_PORTS-1:0]  read_pr,
    output logic [`RT_READ_PORTS-1:0]                 read_ready,

    // writeback sets
    input  logic [`RT_SET_PORTS-1:0]                  set_valid,
    input  core_types_pkg::pr_t [`RT_SET_PORTS-1:0]   set_pr,

    // allocation clears
    input  logic [`RT_CLEAR_PORTS-1:0]                clear_valid,
    input  core_types_pkg::pr_t [`RT_CLEAR_PORTS-1:0] clear_pr
);

    // ----------------------------
    // state
    // ----------------------------

    // PRs below AR_COUNT hold the initial mapping and start ready
    localparam logic [`PR_COUNT-1:0] RESET_READY =
        {{(`PR_COUNT - `AR_COUNT){1'b0}}, {`AR_COUNT{1'b1}}};

    logic [`PR_COUNT-1:0] ready_q;
    logic [`PR_COUNT-1:0] ready_d;

    // ----------------------------
    // next state
    // ----------------------------

    always_comb begin
        ready_d = ready_q;
        // sets first
        for (int s = 0; s < `RT_SET_PORTS; s++) begin
            if (set_valid[s]) begin
                ready_d[set_pr[s]] = 1'b1;
            end
        end
        // clears after, so clear beats set on the same PR
        for (int c = 0; c < `RT_CLEAR_PORTS; c++) begin
            if (clear_valid[c]) begin
                ready_d[clear_pr[c]] = 1'b0;
            end
        end
    end

    // reads see this cycle's sets and clears
    always_comb begin
        for (int r = 0; r < `RT_READ_PORTS; r++) begin
            read_ready[r] = ready_d[read_pr[r]];
        end
    end

    // ----------------------------
    // flops
    // ----------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ready_q <= RESET_READY;
        end else begin
            ready_q <= ready_d;
        end
    end

endmodule

`default_nettype wire

// ==== rename_alloc.sv ====
// ----------------------------
// destination grant, stall and
// source readiness routing
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module rename_alloc (
    input  core_types_pkg::lane_mask_t                 lane_valid,
    input  core_types_pkg::lane_mask_t                 dest_needed,
    // lane i src 0 at 2i, src 1 at 2i+1
    input  core_types_pkg::pr_t [`RT_READ_PORTS-1:0]   src_pr,

    // free list side
    input  core_types_pkg::pr_t [`RENAME_WIDTH-1:0]    head_pr,
    input  logic [`LOG_PR_COUNT:0]                     free_count,
    output logic [`LANE_CNT_WIDTH-1:0]                 pop_count,

    // ready table side
    output core_types_pkg::pr_t [`RT_READ_PORTS-1:0]   read_pr,
    input  logic [`RT_READ_PORTS-1:0]                  read_ready,
    output logic [`RT_CLEAR_PORTS-1:0]                 clear_valid,
    output core_types_pkg::pr_t [`RT_CLEAR_PORTS-1:0]  clear_pr,

    // group results
    output logic                                       accepted,
    output core_types_pkg::pr_t [`RENAME_WIDTH-1:0]    dest_pr,
    output logic [`RT_READ_PORTS-1:0]                  src_ready
);

    import core_types_pkg::*;

    localparam int LCW = `LANE_CNT_WIDTH;

    lane_mask_t     need;
    logic [LCW-1:0] need_cnt;
    logic [LCW-1:0] slot;

    // ----------------------------
    // stall check
    // ----------------------------

    assign need = lane_valid & dest_needed;

    always_comb begin
        need_cnt = '0;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            need_cnt = need_cnt + LCW'(need[l]);
        end
    end

    // whole group waits if free list is short
    assign accepted  = (free_count >= need_cnt);
    assign pop_count = accepted ? need_cnt : '0;

    // ----------------------------
    // grant, needing lanes take head entries in lane order
    // ----------------------------

    always_comb begin
        slot = '0;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            dest_pr[l]     = need[l] ? head_pr[slot] : '0;
            clear_pr[l]    = head_pr[slot];
            clear_valid[l] = accepted & need[l];
            if (need[l]) begin
                slot = slot + LCW'(1);
            end
        end
    end

    // sources out to read ports, readiness back per lane
    always_comb begin
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            read_pr[2*l]     = src_pr[2*l];
            read_pr[2*l+1]   = src_pr[2*l+1];
            src_ready[2*l]   = read_ready[2*l];
            src_ready[2*l+1] = read_ready[2*l+1];
        end
    end

endmodule

`default_nettype wire

// ==== rename_tb.sv ====
// ------------------------------
// rename slice testbench with LFSR stimulus
// and a ready bit and free list reference model
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module rename_tb;

    import core_types_pkg::*;

    localparam int RAND_CYCLES = 400;
    // reset, directed part, random part, then slack
    localparam int WATCHDOG_NS = (4 + 40 + RAND_CYCLES) * 100 + 5000;

    // ------------------------------
    // DUT signals
    // ------------------------------

    logic                       CLK;
    logic                       nRST;
    lane_mask_t                 lane_valid;
    lane_mask_t                 dest_needed;
    pr_t [`RT_READ_PORTS-1:0]   src_pr;
    logic [`RT_SET_PORTS-1:0]   wb_valid;
    pr_t [`RT_SET_PORTS-1:0]    wb_pr;
    logic [`COMMIT_WIDTH-1:0]   commit_valid;
    pr_t [`COMMIT_WIDTH-1:0]    commit_pr;
    logic                       accepted;
    pr_t [`RENAME_WIDTH-1:0]    dest_pr;
    logic [`RT_READ_PORTS-1:0]  src_ready;

    // stimulus staged for the next falling edge
    lane_mask_t                 stim_lv;
    lane_mask_t                 stim_dn;
    pr_t [`RT_READ_PORTS-1:0]   stim_src;
    logic [`RT_SET_PORTS-1:0]   stim_wbv;
    pr_t [`RT_SET_PORTS-1:0]    stim_wbp;
    logic [`COMMIT_WIDTH-1:0]   stim_cv;
    pr_t [`COMMIT_WIDTH-1:0]    stim_cp;

    // reference model
    logic [`PR_COUNT-1:0]       model_ready;
    pr_t                        free_q[$];
    // granted and not yet committed
    pr_t                        granted[$];
    logic                       exp_accepted;
    logic [31:0]                lfsr_q;

    tb_clk_gen tb_clk_gen_i (
        .CLK  (CLK),
        .nRST (nRST)
    );

    rename_top rename_top_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .lane_valid   (lane_valid),
        .dest_needed  (dest_needed),
        .src_pr       (src_pr),
        .wb_valid     (wb_valid),
        .wb_pr        (wb_pr),
        .commit_valid (commit_valid),
        .commit_pr    (commit_pr),
        .accepted     (accepted),
        .dest_pr      (dest_pr),
        .src_ready    (src_ready)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val    = {val[30:0], lfsr_q[31]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic clear_stim();
        stim_lv  = '0;
        stim_dn  = '0;
        stim_src = '0;
        stim_wbv = '0;
        stim_wbp = '0;
        stim_cv  = '0;
        stim_cp  = '0;
    endtask

    task automatic drive_inputs();
        lane_valid   = stim_lv;
        dest_needed  = stim_dn;
        src_pr       = stim_src;
        wb_valid     = stim_wbv;
        wb_pr        = stim_wbp;
        commit_valid = stim_cv;
        commit_pr    = stim_cp;
    endtask

    // ------------------------------
    // per cycle drive, check and model update
    // ------------------------------

    task automatic run_cycle();
        logic [`PR_COUNT-1:0] ready_nxt;
        lane_mask_t           need;
        int                   need_cnt;
        int                   slot;
        logic                 exp_acc;
        @(negedge CLK);
        drive_inputs();
        need     = stim_lv & stim_dn;
        need_cnt = 0;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            need_cnt += int'(need[l]);
        end
        // stall when free list is short
        exp_acc      = (free_q.size() >= need_cnt);
        exp_accepted = exp_acc;
        // sets first and then clears of granted PRs
        ready_nxt = model_ready;
        for (int s = 0; s < `RT_SET_PORTS; s++) begin
            if (stim_wbv[s]) begin
                ready_nxt[stim_wbp[s]] = 1'b1;
            end
        end
        if (exp_acc) begin
            for (int k = 0; k < need_cnt; k++) begin
                ready_nxt[free_q[k]] = 1'b0;
            end
        end
        #5;
        // needing lanes take heads in lane order
        if (exp_acc) begin
            slot = 0;
            for (int l = 0; l < `RENAME_WIDTH; l++) begin
                if (need[l]) begin
                    assert (dest_pr[l] === free_q[slot])
                        else abort_run($sformatf(
                            "mismatch at %0t ns: lane %0d dest %0d, model %0d",
                            $time, l, dest_pr[l], free_q[slot]));
                    slot++;
                end
            end
        end
        for (int j = 0; j < `RT_READ_PORTS; j++) begin
            assert (src_ready[j] === ready_nxt[stim_src[j]])
                else abort_run($sformatf(
                    "mismatch at %0t ns: src_ready[%0d] PR %0d is %b, model %b",
                    $time, j, stim_src[j], src_ready[j], ready_nxt[stim_src[j]]));
        end
        // state as of the coming rising edge
        model_ready = ready_nxt;
        if (exp_acc) begin
            for (int k = 0; k < need_cnt; k++) begin
                granted.push_back(free_q.pop_front());
            end
        end
        // commits append in port order
        for (int p = 0; p < `COMMIT_WIDTH; p++) begin
            if (stim_cv[p]) begin
                free_q.push_back(stim_cp[p]);
            end
        end
    endtask

    task automatic random_stim();
        logic [31:0] r;
        int          idx;
        draw_bits(`RENAME_WIDTH, r);
        stim_lv = lane_mask_t'(r);
        draw_bits(`RENAME_WIDTH, r);
        stim_dn = lane_mask_t'(r);
        for (int j = 0; j < `RT_READ_PORTS; j++) begin
            draw_bits(`LOG_PR_COUNT, r);
            stim_src[j] = pr_t'(r);
        end
        for (int s = 0; s < `RT_SET_PORTS; s++) begin
            draw_bits(1, r);
            stim_wbv[s] = r[0];
            draw_bits(`LOG_PR_COUNT, r);
            stim_wbp[s] = pr_t'(r);
        end
        // now and then write back the head PR so set meets clear
        draw_bits(2, r);
        if (r[1:0] == 2'd0 && free_q.size() > 0) begin
            stim_wbv[0] = 1'b1;
            stim_wbp[0] = free_q[0];
        end
        // commits only from granted PRs on about one port in four
        for (int p = 0; p < `COMMIT_WIDTH; p++) begin
            stim_cv[p] = 1'b0;
            stim_cp[p] = '0;
            draw_bits(2, r);
            if (r[1:0] == 2'd3 && granted.size() > 0) begin
                draw_bits(`LOG_PR_COUNT, r);
                idx        = int'(r % granted.size());
                stim_cv[p] = 1'b1;
                stim_cp[p] = granted[idx];
                granted.delete(idx);
            end
        end
    endtask

    // ------------------------------
    // clock edge check and watchdog
    // ------------------------------

    accept_vs_model: assert property (@(posedge CLK) disable iff (!nRST)
                                      accepted === exp_accepted)
        else abort_run($sformatf("mismatch at %0t ns: accepted %b at clock edge, model %b",
                                 $time, accepted, exp_accepted));

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("timeout: test did not finish within %0d ns", WATCHDOG_NS));
    end

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        lfsr_q       = 32'hd4c6a07d;
        exp_accepted = 1'b1;
        // PRs below AR_COUNT start ready and the rest sit in the free list
        model_ready  = {{(`PR_COUNT - `AR_COUNT){1'b0}}, {`AR_COUNT{1'b1}}};
        for (int i = `AR_COUNT; i < `PR_COUNT; i++) begin
            free_q.push_back(pr_t'(i));
        end
        clear_stim();
        drive_inputs();
        wait (nRST === 1'b1);

        // every PR read once straight after reset
        for (int c = 0; c < `PR_COUNT / `RT_READ_PORTS; c++) begin
            clear_stim();
            stim_lv = '1;
            for (int j = 0; j < `RT_READ_PORTS; j++) begin
                stim_src[j] = pr_t'(c * `RT_READ_PORTS + j);
            end
            run_cycle();
        end

        // full group gets 32 to 35
        clear_stim();
        stim_lv = '1;
        stim_dn = '1;
        run_cycle();
        // writeback of 32 seen the same cycle while 33..35 stay busy
        clear_stim();
        stim_lv = '1;
        for (int j = 0; j < `RENAME_WIDTH; j++) begin
            stim_src[j] = pr_t'(32 + j);
        end
        stim_wbv[0] = 1'b1;
        stim_wbp[0] = pr_t'(32);
        run_cycle();
        clear_stim();
        stim_lv     = '1;
        stim_src[0] = pr_t'(32);
        run_cycle();

        // lanes 1 and 3 only with the head PR also written back
        clear_stim();
        stim_lv     = '1;
        stim_dn     = 4'b1010;
        stim_wbv[0] = 1'b1;
        stim_wbp[0] = free_q[0];
        run_cycle();
        clear_stim();
        stim_lv     = '1;
        stim_src[0] = pr_t'(36);
        stim_src[1] = pr_t'(37);
        run_cycle();

        // drain until short
        while (free_q.size() >= `RENAME_WIDTH) begin
            clear_stim();
            stim_lv = '1;
            stim_dn = '1;
            run_cycle();
        end
        // group held and then commits arrive while it waits
        clear_stim();
        stim_lv = '1;
        stim_dn = '1;
        run_cycle();
        for (int p = 0; p < `COMMIT_WIDTH; p++) begin
            stim_cv[p] = 1'b1;
            stim_cp[p] = granted.pop_front();
        end
        run_cycle();
        // retry takes old heads first and then commits in port order
        clear_stim();
        stim_lv = '1;
        stim_dn = '1;
        run_cycle();

        // random traffic
        for (int n = 0; n < RAND_CYCLES; n++) begin
            random_stim();
            run_cycle();
        end
        @(negedge CLK);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_top.sv ====
// ----------------------------
// rename slice top, ready table + free list + allocator
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module rename_top (
    input  logic                                      CLK,
    input  logic                                      nRST,

    // instruction group
    input  core_types_pkg::lane_mask_t                lane_valid,
    input  core_types_pkg::lane_mask_t                dest_needed,
    input  core_types_pkg::pr_t [`RT_READ_PORTS-1:0]  src_pr,

    // writeback
    input  logic [`RT_SET_PORTS-1:0]                  wb_valid,
    input  core_types_pkg::pr_t [`RT_SET_PORTS-1:0]   wb_pr,

    // commit frees
    input  logic [`COMMIT_WIDTH-1:0]                  commit_valid,
    input  core_types_pkg::pr_t [`COMMIT_WIDTH-1:0]   commit_pr,

    // results, same cycle
    output logic                                      accepted,
    output core_types_pkg::pr_t [`RENAME_WIDTH-1:0]   dest_pr,
    output logic [`RT_READ_PORTS-1:0]                 src_ready
);

    import core_types_pkg::*;

    // ----------------------------
    // internal wires
    // ----------------------------

    pr_t [`RT_READ_PORTS-1:0]   read_pr;
    logic [`RT_READ_PORTS-1:0]  read_ready;
    logic [`RT_CLEAR_PORTS-1:0] clear_valid;
    pr_t [`RT_CLEAR_PORTS-1:0]  clear_pr;
    pr_t [`RENAME_WIDTH-1:0]    head_pr;
    logic [`LOG_PR_COUNT:0]     free_count;
    logic [`LANE_CNT_WIDTH-1:0] pop_count;

    // ----------------------------
    // blocks
    // ----------------------------

    // writeback sets go straight in
    ready_table ready_table_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .read_pr     (read_pr),
        .read_ready  (read_ready),
        .set_valid   (wb_valid),
        .set_pr      (wb_pr),
        .clear_valid (clear_valid),
        .clear_pr    (clear_pr)
    );

    // commits append in port order
    free_list free_list_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .head_pr    (head_pr),
        .free_count (free_count),
        .pop_count  (pop_count),
        .push_valid (commit_valid),
        .push_pr    (commit_pr)
    );

    rename_alloc rename_alloc_i (
        .lane_valid  (lane_valid),
        .dest_needed (dest_needed),
        .src_pr      (src_pr),
        .head_pr     (head_pr),
        .free_count  (free_count),
        .pop_count   (pop_count),
        .read_pr     (read_pr),
        .read_ready  (read_ready),
        .clear_valid (clear_valid),
        .clear_pr    (clear_pr),
        .accepted    (accepted),
        .dest_pr     (dest_pr),
        .src_ready   (src_ready)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
core_types_pkg.sv
ready_table.sv
free_list.sv
rename_alloc.sv
rename_top.sv
tb_clk_gen.sv
rename_tb.sv

// ==== tb_clk_gen.sv ====
// ------------------------------
// testbench clock and reset source
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic CLK,
    output logic nRST
);

    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES   = 4;

    // free running, 100 ns period
    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD_NS) CLK = ~CLK;
    end

    // low from time 0, released on the 4th rising edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire
